// ==== source/tpu_config.svh ====
// ==================================================
// tpu configuration
// array size and element width for the matrix unit
// ==================================================

`ifndef TPU_CONFIG_SVH
`define TPU_CONFIG_SVH

// rows, columns and beats per job
`define ARRAY_DIM 4

// bits per element and per accumulator
`define DATA_WIDTH 8

`endif

// ==== source/tpu_pkg.sv ====
// ==================================================
// tpu package
// shared element, word, row index and phase types
// ==================================================

`default_nettype none

`include "tpu_config.svh"

package tpu_pkg;

        // one element or accumulator, wraps modulo 2^DATA_WIDTH
        typedef logic [`DATA_WIDTH-1:0] data_t;

        // element 0 sits in the most significant byte
        typedef logic [0:`ARRAY_DIM-1][`DATA_WIDTH-1:0] word_t;

        typedef logic [$clog2(`ARRAY_DIM)-1:0] row_idx_t;

        typedef enum logic [2:0] {IDLE, COMPUTE, SETTLE, DRAIN, DONE} phase_t;

endpackage

`default_nettype wire

// ==== source/tpu_sequencer.sv ====
// ==================================================
// tpu sequencer
// job phase FSM, load window and compute timing
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tpu_sequencer (
        input  logic clk,
        input  logic rst_n,
        input  logic in_valid,
        input  logic finished,
        output logic in_ready,
        output logic clear,
        output logic compute,
        output logic load,
        output logic drain_start,
        output logic done
);

        import tpu_pkg::*;

        // compute runs 3*N cycles counting the start edge
        localparam int CNT_W = $clog2(3 * `ARRAY_DIM + 1);

        phase_t           state;
        phase_t           state_next;
        logic [CNT_W-1:0] cycle_cnt;

        // ==================================================
        // next state
        // ==================================================
        always_comb begin
                state_next = state;
                case (state)
                        IDLE:    if (in_valid && in_ready) state_next = COMPUTE;
                        COMPUTE: if (cycle_cnt == CNT_W'(3 * `ARRAY_DIM)) state_next = SETTLE;
                        SETTLE:  state_next = DRAIN;
                        DRAIN:   if (finished) state_next = DONE;
                        DONE:    state_next = IDLE;
                        default: state_next = IDLE;
                endcase
        end

        // load window covers the start edge plus N-1 compute cycles
        assign in_ready = (state == IDLE) ||
                          (state == COMPUTE && cycle_cnt < CNT_W'(`ARRAY_DIM));
        assign load     = in_valid && in_ready;
        assign clear    = (state_next == IDLE);
        assign compute  = (state_next == COMPUTE);

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state       <= IDLE;
                        cycle_cnt   <= '0;
                        drain_start <= 1'b0;
                        done        <= 1'b0;
                end else begin
                        state <= state_next;
                        // counter is 1 right after the start edge
                        if (state_next == COMPUTE)
                                cycle_cnt <= cycle_cnt + 1'b1;
                        else
                                cycle_cnt <= '0;
                        // high during settle, row 0 loads as drain begins
                        drain_start <= (state_next == SETTLE);
                        done        <= (state_next == DONE);
                end
        end

endmodule

`default_nettype wire

// ==== source/skew_buffer.sv ====
// ==================================================
// skew buffer
// triangular delay lines, lane k is held k cycles
// so operands reach the array edge staggered
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module skew_buffer (
        input  logic           clk,
        input  logic           rst_n,
        input  logic           clear,
        input  logic           shift,
        input  logic           load,
        input  tpu_pkg::word_t lanes,
        output tpu_pkg::word_t edge_out
);

        import tpu_pkg::*;

        genvar k;

        generate
                for (k = 0; k < `ARRAY_DIM; k++) begin : gen_lane
                        // depth k+1, stage 0 takes the new byte
                        data_t line [k+1];

                        always_ff @(posedge clk or negedge rst_n) begin
                                if (!rst_n) begin
                                        for (int m = 0; m <= k; m++)
                                                line[m] <= '0;
                                end else if (clear) begin
                                        for (int m = 0; m <= k; m++)
                                                line[m] <= '0;
                                end else if (shift) begin
                                        // idle cycles in the window push a zero bubble
                                        line[0] <= load ? lanes[k] : '0;
                                        for (int m = 1; m <= k; m++)
                                                line[m] <= line[m-1];
                                end
                        end

                        assign edge_out[k] = line[k];
                end
        endgenerate

endmodule

`default_nettype wire

// ==== source/systolic_array.sv ====
// ==================================================
// systolic array
// output stationary MAC grid, a flows right
// and b flows down one cell per cycle
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module systolic_array (
        input  logic           clk,
        input  logic           rst_n,
        input  logic           clear,
        input  logic           compute,
        input  tpu_pkg::word_t row_edge,
        input  tpu_pkg::word_t col_edge,
        output tpu_pkg::word_t acc [`ARRAY_DIM]
);

        import tpu_pkg::*;

        // registered operands leaving each cell
        data_t a_pass [`ARRAY_DIM][`ARRAY_DIM];
        data_t b_pass [`ARRAY_DIM][`ARRAY_DIM];

        genvar i, j;

        generate
                for (i = 0; i < `ARRAY_DIM; i++) begin : gen_row
                        for (j = 0; j < `ARRAY_DIM; j++) begin : gen_col
                                data_t a_in;
                                data_t b_in;
                                data_t a_q;
                                data_t b_q;
                                data_t sum_q;

                                // edge cells take the skewed vectors
                                assign a_in = (j == 0) ? row_edge[i] : a_pass[i][(j == 0) ? 0 : j-1];
                                assign b_in = (i == 0) ? col_edge[j] : b_pass[(i == 0) ? 0 : i-1][j];

                                always_ff @(posedge clk or negedge rst_n) begin
                                        if (!rst_n || clear) begin
                                                a_q   <= '0;
                                                b_q   <= '0;
                                                sum_q <= '0;
                                        end else if (compute) begin
                                                a_q   <= a_in;
                                                b_q   <= b_in;
                                                // product and sum both wrap to DATA_WIDTH
                                                sum_q <= sum_q + a_q * b_q;
                                        end
                                end

                                assign a_pass[i][j] = a_q;
                                assign b_pass[i][j] = b_q;
                                assign acc[i][j]    = sum_q;
                        end
                end
        endgenerate

endmodule

`default_nettype wire

// ==== source/result_drain.sv ====
// ==================================================
// result drain
// reads the accumulator grid out one row per
// valid/ready transfer, row 0 first
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module result_drain (
        input  logic           clk,
        input  logic           rst_n,
        input  logic           drain_start,
        input  logic           out_ready,
        input  tpu_pkg::word_t acc [`ARRAY_DIM],
        output tpu_pkg::word_t out,
        output logic           out_valid,
        output logic           finished
);

        import tpu_pkg::*;

        row_idx_t row;
        row_idx_t row_next;
        logic     xfer;
        logic     last_row;

        assign xfer     = out_valid && out_ready;
        assign last_row = (row == row_idx_t'(`ARRAY_DIM - 1));
        assign row_next = row + 1'b1;

        // pulses on the edge that moves the final row
        assign finished = xfer && last_row;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out       <= '0;
                        out_valid <= 1'b0;
                        row       <= '0;
                end else if (drain_start) begin
                        out       <= acc[0];
                        out_valid <= 1'b1;
                        row       <= '0;
                end else if (xfer) begin
                        if (last_row) begin
                                out_valid <= 1'b0;
                        end else begin
                                row <= row_next;
                                out <= acc[row_next];
                        end
                end
        end

endmodule

`default_nettype wire

// ==== source/tpu_top.sv ====
// ==================================================
// tpu top
// systolic matrix unit, sequencer plus skew,
// array and drain pipeline
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tpu_top (
        input  logic           clk,
        input  logic           rst_n,
        input  logic           in_valid,
        input  tpu_pkg::word_t a,
        input  tpu_pkg::word_t b,
        input  logic           out_ready,
        output logic           in_ready,
        output tpu_pkg::word_t out,
        output logic           out_valid,
        output logic           done
);

        import tpu_pkg::*;

        logic  clear;
        logic  compute;
        logic  load;
        logic  drain_start;
        logic  finished;
        word_t edge_a;
        word_t edge_b;
        word_t acc_grid [`ARRAY_DIM];

        tpu_sequencer u_sequencer (
                .clk         (clk),
                .rst_n       (rst_n),
                .in_valid    (in_valid),
                .finished    (finished),
                .in_ready    (in_ready),
                .clear       (clear),
                .compute     (compute),
                .load        (load),
                .drain_start (drain_start),
                .done        (done)
        );

        // a enters the rows, b enters the columns
        skew_buffer u_skew_a (
                .clk      (clk),
                .rst_n    (rst_n),
                .clear    (clear),
                .shift    (compute),
                .load     (load),
                .lanes    (a),
                .edge_out (edge_a)
        );

        skew_buffer u_skew_b (
                .clk      (clk),
                .rst_n    (rst_n),
                .clear    (clear),
                .shift    (compute),
                .load     (load),
                .lanes    (b),
                .edge_out (edge_b)
        );

        systolic_array u_array (
                .clk      (clk),
                .rst_n    (rst_n),
                .clear    (clear),
                .compute  (compute),
                .row_edge (edge_a),
                .col_edge (edge_b),
                .acc      (acc_grid)
        );

        result_drain u_drain (
                .clk         (clk),
                .rst_n       (rst_n),
                .drain_start (drain_start),
                .out_ready   (out_ready),
                .acc         (acc_grid),
                .out         (out),
                .out_valid   (out_valid),
                .finished    (finished)
        );

endmodule

`default_nettype wire

// ==== testbench/tpu_checker.sv ====
// ==================================================
// tpu checker
// watches the DUT ports, models the matrix product
// and compares every transferred row
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tpu_checker (
        input  logic           clk,
        input  logic           rst_n,
        input  logic           in_valid,
        input  logic           in_ready,
        input  tpu_pkg::word_t a,
        input  tpu_pkg::word_t b,
        input  logic           out_ready,
        input  tpu_pkg::word_t out,
        input  logic           out_valid,
        input  logic           done,
        output int             error_count,
        output int             jobs_done
);

        import tpu_pkg::*;

        localparam int N       = `ARRAY_DIM;
        localparam int MODULUS = 1 << `DATA_WIDTH;

        word_t  expected_rows [N];
        word_t  held_out;
        phase_t phase;
        logic   active;
        logic   hold_pending;
        int     cyc;
        int     row_cnt;
        int     last_cyc;

        task automatic check_bit(input string sig, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("ERROR %s: expected 0x%h got 0x%h (%s, cycle %0d)",
                                 sig, expected, actual, phase.name(), cyc);
                        error_count++;
                end
        endtask

        task automatic check_out(input word_t expected);
                if (out !== expected) begin
                        $display("ERROR out: expected 0x%h got 0x%h (%s, row %0d)",
                                 expected, out, phase.name(), row_cnt);
                        error_count++;
                end
        endtask

        // cell (i,j) gains a[i]*b[j], wrapped to the element width
        task automatic accumulate_beat(input word_t va, input word_t vb);
                int prod;
                for (int i = 0; i < N; i++) begin
                        for (int j = 0; j < N; j++) begin
                                prod = int'(va[i]) * int'(vb[j]);
                                expected_rows[i][j] =
                                        data_t'((int'(expected_rows[i][j]) + prod) % MODULUS);
                        end
                end
        endtask

        // ==================================================
        // per edge model, sampled before the edge updates
        // ==================================================
        always @(posedge clk) begin
                if (!rst_n) begin
                        active       = 1'b0;
                        hold_pending = 1'b0;
                        cyc          = 0;
                        phase        = IDLE;
                        error_count  = 0;
                        jobs_done    = 0;
                end else if (!active) begin
                        phase = IDLE;
                        check_bit("in_ready", 1'b1, in_ready);
                        check_bit("out_valid", 1'b0, out_valid);
                        check_bit("done", 1'b0, done);
                        if (in_valid && in_ready) begin
                                active  = 1'b1;
                                cyc     = 0;
                                row_cnt = 0;
                                for (int i = 0; i < N; i++)
                                        expected_rows[i] = '0;
                                accumulate_beat(a, b);
                        end
                end else begin
                        cyc++;
                        if (done === 1'b1)
                                phase = DONE;
                        else if (cyc <= 3 * N)
                                phase = COMPUTE;
                        else if (cyc == 3 * N + 1)
                                phase = SETTLE;
                        else
                                phase = DRAIN;
                        // load window is the start edge plus N-1 edges
                        if (cyc < N) begin
                                check_bit("in_ready", 1'b1, in_ready);
                                if (in_valid && in_ready)
                                        accumulate_beat(a, b);
                        end else begin
                                check_bit("in_ready", 1'b0, in_ready);
                        end
                        if (cyc < 3 * N + 2)
                                check_bit("out_valid", 1'b0, out_valid);
                        else if (cyc == 3 * N + 2)
                                check_bit("out_valid", 1'b1, out_valid);
                        // a stalled row holds until it is taken
                        if (hold_pending) begin
                                check_bit("out_valid", 1'b1, out_valid);
                                check_out(held_out);
                        end
                        hold_pending = (out_valid === 1'b1) && (out_ready === 1'b0);
                        held_out     = out;
                        if (out_valid === 1'b1 && out_ready === 1'b1) begin
                                if (row_cnt >= N) begin
                                        $display("extra row transferred after the last row");
                                        error_count++;
                                end else begin
                                        check_out(expected_rows[row_cnt]);
                                        row_cnt++;
                                        last_cyc = cyc;
                                end
                        end
                        if (done === 1'b1) begin
                                if (row_cnt != N || cyc != last_cyc + 1) begin
                                        $display("done did not follow the last row by one cycle");
                                        error_count++;
                                end
                                check_bit("out_valid", 1'b0, out_valid);
                                active       = 1'b0;
                                hold_pending = 1'b0;
                                jobs_done++;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== testbench/tb_tpu.sv ====
// ==================================================
// tpu testbench
// seeded random jobs with input gaps and random
// output back-pressure, checked by tpu_checker
// ==================================================

`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tb_tpu;

        import tpu_pkg::*;

        localparam int SEED         = 31;
        localparam int JOBS         = 20;
        localparam int IDLE_TIMEOUT = 50;
        localparam int DONE_TIMEOUT = 400;

        logic        clk;
        logic        rst_n;
        logic        in_valid;
        logic        out_ready;
        logic        in_ready;
        logic        out_valid;
        logic        done;
        word_t       a;
        word_t       b;
        word_t       out;
        int          error_count;
        int          jobs_done;
        int          timeout_errors;
        int          total_errors;
        logic        aborted;

        tpu_top dut (.*);

        tpu_checker u_checker (.*);

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // inputs change 1 ns after the rising edge
        task automatic next_cycle();
                @(posedge clk);
                #1;
        endtask

        function automatic word_t random_word();
                word_t w;
                for (int k = 0; k < `ARRAY_DIM; k++)
                        w[k] = data_t'($urandom_range(0, 255));
                return w;
        endfunction

        // a and b change even while in_valid is low
        task automatic drive_inputs(input logic valid);
                in_valid  = valid;
                a         = random_word();
                b         = random_word();
                out_ready = ($urandom_range(0, 3) != 0);
        endtask

        task automatic wait_for_idle();
                int waited;
                waited = 0;
                while (in_ready !== 1'b1 && waited < IDLE_TIMEOUT) begin
                        next_cycle();
                        waited++;
                end
                if (in_ready !== 1'b1) begin
                        $display("timeout: in_ready stayed low after the previous job");
                        timeout_errors++;
                        aborted = 1'b1;
                end
        endtask

        task automatic run_job();
                int waited;
                waited = 0;
                wait_for_idle();
                if (!aborted) begin
                        repeat ($urandom_range(0, 2)) begin
                                drive_inputs(1'b0);
                                next_cycle();
                        end
                        // beat 0 starts the job, later beats may have gaps
                        drive_inputs(1'b1);
                        next_cycle();
                        repeat (`ARRAY_DIM - 1) begin
                                drive_inputs($urandom_range(0, 9) < 7);
                                next_cycle();
                        end
                        while (done !== 1'b1 && waited < DONE_TIMEOUT) begin
                                drive_inputs($urandom_range(0, 1) == 1);
                                next_cycle();
                                waited++;
                        end
                        in_valid = 1'b0;
                        if (done !== 1'b1) begin
                                $display("timeout: done never pulsed for job %0d", jobs_done);
                                timeout_errors++;
                                aborted = 1'b1;
                        end
                end
        endtask

        initial begin
                in_valid       = 1'b0;
                a              = '0;
                b              = '0;
                out_ready      = 1'b0;
                rst_n          = 1'b0;
                timeout_errors = 0;
                aborted        = 1'b0;
                void'($urandom(SEED));
                repeat (5) @(posedge clk);
                #1;
                rst_n = 1'b1;
                for (int job = 0; job < JOBS && !aborted; job++)
                        run_job();
                repeat (3) next_cycle();
                total_errors = error_count + timeout_errors;
                if (jobs_done != JOBS) begin
                        $display("only %0d of %0d jobs finished", jobs_done, JOBS);
                        total_errors++;
                end
                $display("jobs %0d of %0d, checker errors %0d, timeouts %0d, total errors %0d",
                         jobs_done, JOBS, error_count, timeout_errors, total_errors);
                if (total_errors == 0)
                        $display("PASS: all tests");
                else
                        $display("FAIL: see errors above");
                $finish;
        end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+source
source/tpu_pkg.sv
source/tpu_sequencer.sv
source/skew_buffer.sv
source/systolic_array.sv
source/result_drain.sv
source/tpu_top.sv
testbench/tpu_checker.sv
testbench/tb_tpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
        -f flist.f --top-module tb_tpu -o sim_tpu

output=$(./obj_dir/sim_tpu 2>&1) || true
echo "$output"

if echo "$output" | grep -q "PASS: all tests"; then
        exit 0
fi
exit 1
